// File: verilog/stap_pkg.sv
`default_nettype none

package stap_pkg;

   // ***********************************************************
   // Widths that carry a meaning
   // ***********************************************************

   // Identification code word, bit 0 always 1
   typedef logic [31:0] id_word_t;

   // Low opcode nibble, zero-extended to the instruction width
   typedef logic [3:0] opc_nibble_t;

   // ***********************************************************
   // TAP controller states
   // ***********************************************************

   // Encoding follows the usual 1149.1 state numbering
   typedef enum logic [3:0] {
      TLR        = 4'hF,
      RTI        = 4'hC,
      SELECT_DR  = 4'h7,
      CAPTURE_DR = 4'h6,
      SHIFT_DR   = 4'h2,
      EXIT1_DR   = 4'h1,
      PAUSE_DR   = 4'h3,
      EXIT2_DR   = 4'h0,
      UPDATE_DR  = 4'h5,
      SELECT_IR  = 4'h4,
      CAPTURE_IR = 4'hE,
      SHIFT_IR   = 4'hA,
      EXIT1_IR   = 4'h9,
      PAUSE_IR   = 4'hB,
      EXIT2_IR   = 4'h8,
      UPDATE_IR  = 4'hD
   } stap_state_t;

   // Control strobes decoded from the current TAP state
   typedef struct packed {
      logic tlrs;
      logic capture_ir;
      logic shift_ir;
      logic update_ir;
      logic capture_dr;
      logic shift_dr;
      logic update_dr;
   } stap_ctrl_t;

   // ***********************************************************
   // Instruction opcodes
   // ***********************************************************
   localparam opc_nibble_t OPC_IDCODE    = 4'h2;
   localparam opc_nibble_t OPC_SLVIDCODE = 4'hC;
   localparam opc_nibble_t OPC_USERDATA  = 4'h5;

   // Fixed pattern loaded into the IR shift stage in Capture-IR
   localparam logic [1:0] IR_CAPTURE = 2'b01;

endpackage

`default_nettype wire

// File: verilog/stap_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module stap_fsm
   (
   input  logic                 ftap_tck,
   input  logic                 powergoodrst_trst_b,
   input  logic                 ftap_tms,
   output stap_pkg::stap_ctrl_t stap_ctrl,
   output logic                 shift_ir_dr,
   output logic                 shift_ir_sel
   );

   import stap_pkg::*;

   // Current and next TAP state
   stap_state_t state;
   stap_state_t state_nxt;

   // ***********************************************************
   // State register
   // ***********************************************************

   // Power-good reset forces Test-Logic-Reset
   always_ff @(posedge ftap_tck or negedge powergoodrst_trst_b)
   begin
      if (!powergoodrst_trst_b)
      begin
         state <= TLR;
      end
      else
      begin
         state <= state_nxt;
      end
   end

   // ***********************************************************
   // Next state, standard TAP graph
   // ***********************************************************
   always_comb
   begin
      case (state)
         TLR:        state_nxt = ftap_tms ? TLR        : RTI;
         RTI:        state_nxt = ftap_tms ? SELECT_DR  : RTI;
         // DR column
         SELECT_DR:  state_nxt = ftap_tms ? SELECT_IR  : CAPTURE_DR;
         CAPTURE_DR: state_nxt = ftap_tms ? EXIT1_DR   : SHIFT_DR;
         SHIFT_DR:   state_nxt = ftap_tms ? EXIT1_DR   : SHIFT_DR;
         EXIT1_DR:   state_nxt = ftap_tms ? UPDATE_DR  : PAUSE_DR;
         PAUSE_DR:   state_nxt = ftap_tms ? EXIT2_DR   : PAUSE_DR;
         EXIT2_DR:   state_nxt = ftap_tms ? UPDATE_DR  : SHIFT_DR;
         UPDATE_DR:  state_nxt = ftap_tms ? SELECT_DR  : RTI;
         // IR column, TMS high in Select-IR escapes to reset
         SELECT_IR:  state_nxt = ftap_tms ? TLR        : CAPTURE_IR;
         CAPTURE_IR: state_nxt = ftap_tms ? EXIT1_IR   : SHIFT_IR;
         SHIFT_IR:   state_nxt = ftap_tms ? EXIT1_IR   : SHIFT_IR;
         EXIT1_IR:   state_nxt = ftap_tms ? UPDATE_IR  : PAUSE_IR;
         PAUSE_IR:   state_nxt = ftap_tms ? EXIT2_IR   : PAUSE_IR;
         EXIT2_IR:   state_nxt = ftap_tms ? UPDATE_IR  : SHIFT_IR;
         UPDATE_IR:  state_nxt = ftap_tms ? SELECT_DR  : RTI;
         default:    state_nxt = TLR;
      endcase
   end

   // ***********************************************************
   // Control strobe decode
   // ***********************************************************

   // Pure decodes of the current state, acted on at the exiting edge
   always_comb
   begin
      stap_ctrl.tlrs       = (state == TLR);
      stap_ctrl.capture_ir = (state == CAPTURE_IR);
      stap_ctrl.shift_ir   = (state == SHIFT_IR);
      stap_ctrl.update_ir  = (state == UPDATE_IR);
      stap_ctrl.capture_dr = (state == CAPTURE_DR);
      stap_ctrl.shift_dr   = (state == SHIFT_DR);
      stap_ctrl.update_dr  = (state == UPDATE_DR);
   end

   // Either shift state enables the serial output
   assign shift_ir_dr  = (state == SHIFT_IR) || (state == SHIFT_DR);

   // High when the running shift goes through the instruction path
   assign shift_ir_sel = (state == SHIFT_IR);

endmodule

`default_nettype wire

// File: verilog/stap_irreg.sv
`timescale 1ns/100ps
`default_nettype none

module stap_irreg
   #(
   parameter int IR_WIDTH = 8
   )
   (
   input  logic                 ftap_tck,
   input  logic                 powergoodrst_trst_b,
   input  logic                 ftap_tdi,
   input  stap_pkg::stap_ctrl_t stap_ctrl,
   output logic [IR_WIDTH-1:0]  stap_ireg,
   output logic                 ir_serial_out
   );

   import stap_pkg::*;

   // Capture pattern and reset instruction at full width
   localparam logic [IR_WIDTH-1:0] IR_CAPTURE_WORD = IR_WIDTH'(IR_CAPTURE);
   localparam logic [IR_WIDTH-1:0] IR_SLVIDCODE    = IR_WIDTH'(OPC_SLVIDCODE);

   logic [IR_WIDTH-1:0] shift_reg;

   // ***********************************************************
   // Shift stage, rising edge
   // ***********************************************************

   // Holds 01 in reset and in Test-Logic-Reset
   // Reloads 01 in Capture-IR
   // TDI enters at the MSB, LSB leaves first
   always_ff @(posedge ftap_tck or negedge powergoodrst_trst_b)
   begin
      if (!powergoodrst_trst_b)
      begin
         shift_reg <= IR_CAPTURE_WORD;
      end
      else if (stap_ctrl.tlrs || stap_ctrl.capture_ir)
      begin
         shift_reg <= IR_CAPTURE_WORD;
      end
      else if (stap_ctrl.shift_ir)
      begin
         shift_reg <= {ftap_tdi, shift_reg[IR_WIDTH-1:1]};
      end
   end

   // Serial bit towards the TDO stage
   assign ir_serial_out = shift_reg[0];

   // ***********************************************************
   // Parallel instruction register, falling edge
   // ***********************************************************

   // Loaded mid-cycle in Update-IR so the new opcode is stable
   // before the next rising edge
   always_ff @(negedge ftap_tck or negedge powergoodrst_trst_b)
   begin
      if (!powergoodrst_trst_b)
      begin
         stap_ireg <= IR_SLVIDCODE;
      end
      else if (stap_ctrl.tlrs)
      begin
         stap_ireg <= IR_SLVIDCODE;
      end
      else if (stap_ctrl.update_ir)
      begin
         stap_ireg <= shift_reg;
      end
   end

endmodule

`default_nettype wire

// File: verilog/stap_datareg.sv
`timescale 1ns/100ps
`default_nettype none

module stap_datareg
   #(
   parameter int                 IR_WIDTH        = 8,
   parameter int                 USER_WIDTH      = 16,
   parameter stap_pkg::id_word_t IDCODE_VALUE    = 32'h1ABCD0C3,
   parameter stap_pkg::id_word_t SLVIDCODE_VALUE = 32'h0F00D0E5
   )
   (
   input  logic                  ftap_tck,
   input  logic                  powergoodrst_trst_b,
   input  logic                  ftap_tdi,
   input  stap_pkg::stap_ctrl_t  stap_ctrl,
   input  logic [IR_WIDTH-1:0]   stap_ireg,
   output logic                  dr_serial_out,
   output logic [USER_WIDTH-1:0] user_data
   );

   import stap_pkg::*;

   // Opcodes widened to the instruction register
   localparam logic [IR_WIDTH-1:0] IR_IDCODE    = IR_WIDTH'(OPC_IDCODE);
   localparam logic [IR_WIDTH-1:0] IR_SLVIDCODE = IR_WIDTH'(OPC_SLVIDCODE);
   localparam logic [IR_WIDTH-1:0] IR_USERDATA  = IR_WIDTH'(OPC_USERDATA);

   // Register selects, exactly one is high
   logic sel_idcode;
   logic sel_slvidcode;
   logic sel_user;
   logic sel_bypass;

   logic                  bypass_reg;
   id_word_t              id_shift;
   logic [USER_WIDTH-1:0] user_shift;

   // ***********************************************************
   // Instruction decode
   // ***********************************************************
   assign sel_idcode    = (stap_ireg == IR_IDCODE);
   assign sel_slvidcode = (stap_ireg == IR_SLVIDCODE);
   assign sel_user      = (stap_ireg == IR_USERDATA);
   // All ones and every unlisted opcode fall through to bypass
   assign sel_bypass    = !(sel_idcode || sel_slvidcode || sel_user);

   // ***********************************************************
   // Bypass bit
   // ***********************************************************

   // Captures 0, so a bypass scan leads with a zero
   always_ff @(posedge ftap_tck or negedge powergoodrst_trst_b)
   begin
      if (!powergoodrst_trst_b)
      begin
         bypass_reg <= 1'b0;
      end
      else if (stap_ctrl.capture_dr)
      begin
         bypass_reg <= 1'b0;
      end
      else if (stap_ctrl.shift_dr && sel_bypass)
      begin
         bypass_reg <= ftap_tdi;
      end
   end

   // ***********************************************************
   // Identification shift register
   // ***********************************************************

   // One 32-bit path serves IDCODE and SLVIDCODE
   always_ff @(posedge ftap_tck)
   begin
      if (stap_ctrl.capture_dr)
      begin
         id_shift <= sel_idcode ? IDCODE_VALUE : SLVIDCODE_VALUE;
      end
      else if (stap_ctrl.shift_dr && (sel_idcode || sel_slvidcode))
      begin
         id_shift <= {ftap_tdi, id_shift[31:1]};
      end
   end

   // ***********************************************************
   // User test data register
   // ***********************************************************

   // Shift stage captures the present parallel value
   always_ff @(posedge ftap_tck)
   begin
      if (stap_ctrl.capture_dr && sel_user)
      begin
         user_shift <= user_data;
      end
      else if (stap_ctrl.shift_dr && sel_user)
      begin
         user_shift <= {ftap_tdi, user_shift[USER_WIDTH-1:1]};
      end
   end

   // Shadow register, updated on the falling edge in Update-DR
   always_ff @(negedge ftap_tck or negedge powergoodrst_trst_b)
   begin
      if (!powergoodrst_trst_b)
      begin
         user_data <= '0;
      end
      else if (stap_ctrl.update_dr && sel_user)
      begin
         user_data <= user_shift;
      end
   end

   // ***********************************************************
   // Serial output select
   // ***********************************************************
   always_comb
   begin
      if (sel_user)
      begin
         dr_serial_out = user_shift[0];
      end
      else if (sel_idcode || sel_slvidcode)
      begin
         dr_serial_out = id_shift[0];
      end
      else
      begin
         dr_serial_out = bypass_reg;
      end
   end

endmodule

`default_nettype wire

// File: verilog/stap_tdomux.sv
`timescale 1ns/100ps
`default_nettype none

module stap_tdomux
   (
   input  logic ftap_tck,
   input  logic powergoodrst_trst_b,
   input  logic shift_ir_dr,
   input  logic shift_ir_sel,
   input  logic ir_serial_out,
   input  logic dr_serial_out,
   output logic atap_tdo,
   output logic atap_tdoen
   );

   // Serial bit of whichever path is shifting
   logic tdo_sel;

   // IR path in Shift-IR, DR path otherwise
   assign tdo_sel = shift_ir_sel ? ir_serial_out : dr_serial_out;

   // ***********************************************************
   // Falling-edge retiming
   // ***********************************************************

   // TDO changes mid-cycle so the far end samples a settled bit
   // on the following rising edge
   // Outside a shift TDO is parked at 0 with the enable low
   always_ff @(negedge ftap_tck or negedge powergoodrst_trst_b)
   begin
      if (!powergoodrst_trst_b)
      begin
         atap_tdo   <= 1'b0;
         atap_tdoen <= 1'b0;
      end
      else
      begin
         atap_tdo   <= shift_ir_dr ? tdo_sel : 1'b0;
         atap_tdoen <= shift_ir_dr;
      end
   end

endmodule

`default_nettype wire

// File: verilog/stap_top.sv
`timescale 1ns/100ps
`default_nettype none

module stap_top
   #(
   parameter int                 IR_WIDTH        = 8,
   parameter int                 USER_WIDTH      = 16,
   parameter stap_pkg::id_word_t IDCODE_VALUE    = 32'h1ABCD0C3,
   parameter stap_pkg::id_word_t SLVIDCODE_VALUE = 32'h0F00D0E5
   )
   (
   input  logic                  ftap_tck,
   input  logic                  powergoodrst_trst_b,
   input  logic                  ftap_tms,
   input  logic                  ftap_tdi,
   output logic                  atap_tdo,
   output logic                  atap_tdoen,
   output logic [USER_WIDTH-1:0] user_data,
   output logic [IR_WIDTH-1:0]   stap_ireg
   );

   import stap_pkg::*;

   // Strobes from the controller
   stap_ctrl_t stap_ctrl;
   logic       shift_ir_dr;
   logic       shift_ir_sel;

   // Serial bits towards the TDO stage
   logic       ir_serial_out;
   logic       dr_serial_out;

   // ***********************************************************
   // TAP controller
   // ***********************************************************
   stap_fsm u_fsm (
      .ftap_tck            (ftap_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b),
      .ftap_tms            (ftap_tms),
      .stap_ctrl           (stap_ctrl),
      .shift_ir_dr         (shift_ir_dr),
      .shift_ir_sel        (shift_ir_sel)
   );

   // Instruction register
   stap_irreg #(
      .IR_WIDTH (IR_WIDTH)
   ) u_irreg (
      .ftap_tck            (ftap_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b),
      .ftap_tdi            (ftap_tdi),
      .stap_ctrl           (stap_ctrl),
      .stap_ireg           (stap_ireg),
      .ir_serial_out       (ir_serial_out)
   );

   // Data registers selected by the instruction
   stap_datareg #(
      .IR_WIDTH        (IR_WIDTH),
      .USER_WIDTH      (USER_WIDTH),
      .IDCODE_VALUE    (IDCODE_VALUE),
      .SLVIDCODE_VALUE (SLVIDCODE_VALUE)
   ) u_datareg (
      .ftap_tck            (ftap_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b),
      .ftap_tdi            (ftap_tdi),
      .stap_ctrl           (stap_ctrl),
      .stap_ireg           (stap_ireg),
      .dr_serial_out       (dr_serial_out),
      .user_data           (user_data)
   );

   // Output stage
   stap_tdomux u_tdomux (
      .ftap_tck            (ftap_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b),
      .shift_ir_dr         (shift_ir_dr),
      .shift_ir_sel        (shift_ir_sel),
      .ir_serial_out       (ir_serial_out),
      .dr_serial_out       (dr_serial_out),
      .atap_tdo            (atap_tdo),
      .atap_tdoen          (atap_tdoen)
   );

endmodule

`default_nettype wire

// File: dv/stap_clkgen.sv
`timescale 1ns/100ps
`default_nettype none

module stap_clkgen
   #(
   parameter int HALF_PERIOD  = 5,
   parameter int RESET_CYCLES = 2
   )
   (
   output logic ftap_tck,
   output logic powergoodrst_trst_b
   );

   // Free-running TCK, 10 ns period
   initial
   begin
      ftap_tck = 1'b0;
      forever
      begin
         #HALF_PERIOD;
         ftap_tck = ~ftap_tck;
      end
   end

   // Power-good reset low for the first rising edges
   // Released just after an edge, like the other inputs
   initial
   begin
      powergoodrst_trst_b = 1'b0;
      repeat (RESET_CYCLES) @(posedge ftap_tck);
      #1;
      powergoodrst_trst_b = 1'b1;
   end

endmodule

`default_nettype wire

// File: dv/stap_assert.sv
`timescale 1ns/100ps
`default_nettype none

module stap_assert
   #(
   parameter int IR_WIDTH = 8
   )
   (
   input  logic                 ftap_tck,
   input  logic                 powergoodrst_trst_b,
   input  stap_pkg::stap_ctrl_t stap_ctrl,
   input  logic                 atap_tdoen,
   input  logic [IR_WIDTH-1:0]  stap_ireg,
   input  logic [IR_WIDTH-1:0]  ir_shift
   );

   // SLVIDCODE opcode 4'hC and the 01 capture pattern, both zero-extended
   localparam logic [IR_WIDTH-1:0] SLVIDCODE_OPC = IR_WIDTH'(4'hC);
   localparam logic [IR_WIDTH-1:0] CAPTURE_WORD  = IR_WIDTH'(2'b01);

   // Failures seen so far, read by the testbench at the end
   int assert_fail_count = 0;

   // ***********************************************************
   // Output enable only while shifting
   // ***********************************************************

   // Enable was set at the falling edge of the same state
   tdoen_in_shift: assert property (
      @(posedge ftap_tck) disable iff (!powergoodrst_trst_b)
      atap_tdoen |-> (stap_ctrl.shift_ir || stap_ctrl.shift_dr))
   else
   begin
      assert_fail_count++;
      $error("atap_tdoen high outside Shift-IR and Shift-DR");
   end

   // ***********************************************************
   // Instruction register in Test-Logic-Reset
   // ***********************************************************
   ireg_in_tlr: assert property (
      @(posedge ftap_tck) disable iff (!powergoodrst_trst_b)
      stap_ctrl.tlrs |-> (stap_ireg == SLVIDCODE_OPC))
   else
   begin
      assert_fail_count++;
      $error("stap_ireg 0x%0h is not SLVIDCODE in Test-Logic-Reset", stap_ireg);
   end

   // Shift stage loaded with 01 by the edge leaving Capture-IR
   ir_capture_pattern: assert property (
      @(posedge ftap_tck) disable iff (!powergoodrst_trst_b)
      stap_ctrl.capture_ir |=> (ir_shift == CAPTURE_WORD))
   else
   begin
      assert_fail_count++;
      $error("IR shift stage 0x%0h after Capture-IR", ir_shift);
   end

endmodule

`default_nettype wire

// File: dv/stap_tb.sv
`timescale 1ns/100ps
`default_nettype none

module stap_tb;

   // DUT configuration, the stap_top defaults
   localparam int          IR_WIDTH        = 8;
   localparam int          USER_WIDTH      = 16;
   localparam logic [31:0] IDCODE_VALUE    = 32'h1ABCD0C3;
   localparam logic [31:0] SLVIDCODE_VALUE = 32'h0F00D0E5;

   // Opcodes at the instruction width
   localparam logic [7:0] OPC_IDCODE_W    = 8'h02;
   localparam logic [7:0] OPC_SLVIDCODE_W = 8'h0C;
   localparam logic [7:0] OPC_USERDATA_W  = 8'h05;
   localparam logic [7:0] OPC_BYPASS_W    = 8'hFF;
   localparam logic [7:0] OPC_UNLISTED_W  = 8'h33;
   // Capture-IR returns 01 with upper zeros
   localparam logic [7:0] IR_CAPTURE_W    = 8'h01;

   // Bound on the reset wait, in TCK cycles
   localparam int RESET_WAIT_LIMIT = 10;

   logic                  ftap_tck;
   logic                  powergoodrst_trst_b;
   logic                  ftap_tms;
   logic                  ftap_tdi;
   logic                  atap_tdo;
   logic                  atap_tdoen;
   logic [USER_WIDTH-1:0] user_data;
   logic [IR_WIDTH-1:0]   stap_ireg;

   integer seed;
   int     test_errors;
   int     total_errors;
   int     tests_run;
   int     tests_failed;
   bit     timed_out;

   // ***********************************************************
   // Clock, reset and DUT
   // ***********************************************************
   stap_clkgen u_clkgen (
      .ftap_tck            (ftap_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b)
   );

   stap_top #(
      .IR_WIDTH        (IR_WIDTH),
      .USER_WIDTH      (USER_WIDTH),
      .IDCODE_VALUE    (IDCODE_VALUE),
      .SLVIDCODE_VALUE (SLVIDCODE_VALUE)
   ) DUT (
      .ftap_tck            (ftap_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b),
      .ftap_tms            (ftap_tms),
      .ftap_tdi            (ftap_tdi),
      .atap_tdo            (atap_tdo),
      .atap_tdoen          (atap_tdoen),
      .user_data           (user_data),
      .stap_ireg           (stap_ireg)
   );

   // Protocol properties on the DUT internals
   bind stap_top stap_assert #(
      .IR_WIDTH (IR_WIDTH)
   ) u_assert (
      .ftap_tck            (ftap_tck),
      .powergoodrst_trst_b (powergoodrst_trst_b),
      .stap_ctrl           (stap_ctrl),
      .atap_tdoen          (atap_tdoen),
      .stap_ireg           (stap_ireg),
      .ir_shift            (u_irreg.shift_reg)
   );

   // ***********************************************************
   // TAP driving
   // ***********************************************************

   // Drives TMS and TDI, one rising edge, then back to the drive point
   task automatic clock_tms(input logic tms, input logic tdi);
      ftap_tms = tms;
      ftap_tdi = tdi;
      @(posedge ftap_tck);
      #1;
   endtask

   // Full scan from Run-Test/Idle back to Run-Test/Idle
   // TDO is sampled on the rising edge that shifts each bit
   task automatic scan_path(input bit is_ir, input int nbits,
                            input logic [31:0] din, output logic [31:0] dout);
      int i;
      dout = '0;
      // To Select-DR, and on to Select-IR for an instruction scan
      clock_tms(1'b1, 1'b0);
      if (is_ir)
      begin
         clock_tms(1'b1, 1'b0);
      end
      // Capture, then into Shift
      clock_tms(1'b0, 1'b0);
      clock_tms(1'b0, 1'b0);
      for (i = 0; i < nbits; i++)
      begin
         // Last bit leaves for Exit1
         ftap_tms = (i == nbits - 1);
         ftap_tdi = din[i];
         @(posedge ftap_tck);
         dout[i] = atap_tdo;
         #1;
      end
      // Exit1 to Update, Update to Run-Test/Idle
      clock_tms(1'b1, 1'b0);
      clock_tms(1'b0, 1'b0);
   endtask

   // ***********************************************************
   // Checking and reporting
   // ***********************************************************
   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp)
      else
      begin
         $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
         test_errors++;
      end
   endtask

   task automatic finish_test(input string name);
      tests_run++;
      if (test_errors == 0)
      begin
         $display("test %0d %s: ok", tests_run, name);
      end
      else
      begin
         tests_failed++;
         $display("test %0d %s: FAILED with %0d errors", tests_run, name, test_errors);
      end
      total_errors += test_errors;
      test_errors = 0;
   endtask

   // Bounded wait for power-good reset release
   task automatic wait_reset_release();
      int cycles;
      cycles = 0;
      while (powergoodrst_trst_b !== 1'b1 && cycles < RESET_WAIT_LIMIT)
      begin
         @(posedge ftap_tck);
         cycles++;
      end
      if (powergoodrst_trst_b !== 1'b1)
      begin
         $display("timeout: power-good reset still asserted after %0d clocks",
                  RESET_WAIT_LIMIT);
         timed_out = 1'b1;
      end
      else
      begin
         #1;
      end
   endtask

   // IR scan, then the captured pattern and new instruction
   task automatic load_instruction(input logic [7:0] opcode);
      logic [31:0] captured;
      scan_path(1'b1, IR_WIDTH, 32'(opcode), captured);
      check_value("atap_tdo (IR capture)", captured, 32'(IR_CAPTURE_W));
      check_value("stap_ireg", 32'(stap_ireg), 32'(opcode));
   endtask

   // ***********************************************************
   // Tests
   // ***********************************************************

   // Still in Test-Logic-Reset after reset
   task automatic reset_defaults();
      logic [31:0] id_word;
      check_value("atap_tdoen", 32'(atap_tdoen), 32'h0);
      check_value("atap_tdo", 32'(atap_tdo), 32'h0);
      check_value("stap_ireg", 32'(stap_ireg), 32'(OPC_SLVIDCODE_W));
      check_value("user_data", 32'(user_data), 32'h0);
      clock_tms(1'b0, 1'b0);
      scan_path(1'b0, 32, 32'h0, id_word);
      check_value("atap_tdo (SLVIDCODE)", id_word, SLVIDCODE_VALUE);
      finish_test("reset defaults and SLVIDCODE");
   endtask

   task automatic idcode_readback();
      logic [31:0] id_word;
      load_instruction(OPC_IDCODE_W);
      scan_path(1'b0, 32, 32'h0, id_word);
      check_value("atap_tdo (IDCODE)", id_word, IDCODE_VALUE);
      finish_test("IR capture and IDCODE");
   endtask

   // Bypass leads with the captured 0, then the pattern one bit late
   task automatic bypass_delay(input logic [7:0] opcode, input string name);
      logic [31:0] pattern;
      logic [31:0] returned;
      load_instruction(opcode);
      pattern = $random(seed);
      scan_path(1'b0, 32, pattern, returned);
      check_value("atap_tdo (bypass)", returned, {pattern[30:0], 1'b0});
      finish_test(name);
   endtask

   // Update on the second scan, read back of the first value
   task automatic user_register_update();
      logic [31:0] first_val;
      logic [31:0] second_val;
      logic [31:0] returned;
      load_instruction(OPC_USERDATA_W);
      first_val  = {16'h0, 16'($random(seed))};
      second_val = {16'h0, 16'($random(seed))};
      scan_path(1'b0, USER_WIDTH, first_val, returned);
      check_value("atap_tdo (user reset value)", returned, 32'h0);
      check_value("user_data", 32'(user_data), first_val);
      scan_path(1'b0, USER_WIDTH, second_val, returned);
      check_value("atap_tdo (user readback)", returned, first_val);
      check_value("user_data", 32'(user_data), second_val);
      finish_test("user data register");
   endtask

   task automatic return_to_reset();
      // Run-Test/Idle into Shift-DR, then one shift clock
      clock_tms(1'b1, 1'b0);
      clock_tms(1'b0, 1'b0);
      clock_tms(1'b0, 1'b0);
      clock_tms(1'b0, 1'b1);
      check_value("atap_tdoen (Shift-DR)", 32'(atap_tdoen), 32'h1);
      repeat (5) clock_tms(1'b1, 1'b0);
      // Instruction reverts at the falling edge after the fifth clock
      clock_tms(1'b1, 1'b0);
      check_value("stap_ireg (Test-Logic-Reset)", 32'(stap_ireg), 32'(OPC_SLVIDCODE_W));
      check_value("atap_tdoen", 32'(atap_tdoen), 32'h0);
      check_value("atap_tdo", 32'(atap_tdo), 32'h0);
      // Leave for Run-Test/Idle
      clock_tms(1'b0, 1'b0);
      finish_test("return to Test-Logic-Reset");
   endtask

   // ***********************************************************
   // Test sequence
   // ***********************************************************
   initial
   begin
      ftap_tms     = 1'b1;
      ftap_tdi     = 1'b0;
      seed         = 32'h54a2a29c;
      test_errors  = 0;
      total_errors = 0;
      tests_run    = 0;
      tests_failed = 0;
      timed_out    = 1'b0;
      wait_reset_release();
      if (!timed_out)
      begin
         reset_defaults();
      end
      if (!timed_out)
      begin
         idcode_readback();
      end
      if (!timed_out)
      begin
         bypass_delay(OPC_BYPASS_W, "bypass opcode");
      end
      if (!timed_out)
      begin
         user_register_update();
      end
      if (!timed_out)
      begin
         return_to_reset();
      end
      if (!timed_out)
      begin
         bypass_delay(OPC_UNLISTED_W, "unlisted opcode as bypass");
      end
      $display("tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
               tests_run, tests_failed, total_errors, DUT.u_assert.assert_fail_count);
      if (!timed_out && tests_failed == 0 && total_errors == 0
          && DUT.u_assert.assert_fail_count == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: compile.f
verilog/stap_pkg.sv
verilog/stap_fsm.sv
verilog/stap_irreg.sv
verilog/stap_datareg.sv
verilog/stap_tdomux.sv
verilog/stap_top.sv
dv/stap_clkgen.sv
dv/stap_assert.sv
dv/stap_tb.sv

// File: Makefile
# Verilator flow for the TAP subsystem

VERILATOR  ?= verilator
TOP        := stap_tb
FILELIST   := compile.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := === PASS ===

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x -F "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
